/* hdc_pkg.sv */
package hdc_pkg;

    // default geometry, the top level overrides and passes these down.
    localparam int DIM   = 64;  // hypervector width.
    localparam int LANES = 8;   // feature lanes per sample.
    localparam int WORD  = 16;  // stream slice width.

    // longest frame the vote counters are sized for.
    localparam int MAX_UPDATES = 32;

    // ones-count and lane total never exceed MAX_UPDATES * LANES.
    localparam int CNT_W = $clog2(MAX_UPDATES * LANES + 1);

    // lane_count runs from 1 to LANES.
    localparam int LC_W = $clog2(LANES + 1);

    // slice select for the stream port.
    localparam int ADDR_W = (DIM / WORD > 1) ? $clog2(DIM / WORD) : 1;

    // one input sample as driven with update.
    typedef struct packed {
        logic [LANES-1:0][DIM-1:0] lanes;       // feature hypervectors, lane 0 in the low bits.
        logic [LC_W-1:0]           lane_count;  // lanes 0 .. lane_count-1 are valid.
        logic                      first;       // opens a frame.
        logic                      last;        // closes a frame.
        logic [DIM-1:0]            tie;         // tie breakers, only read with last.
    } sample_t;

    // binder output, same layout with the lanes already bound.
    typedef struct packed {
        logic [LANES-1:0][DIM-1:0] lanes;       // invalid lanes are zero here.
        logic [LC_W-1:0]           lane_count;
        logic                      first;
        logic                      last;
        logic [DIM-1:0]            tie;
    } bound_t;

endpackage

/* hv_binder.sv */
`timescale 1ns/100ps

module hv_binder #(
    parameter int DIM   = hdc_pkg::DIM,
    parameter int LANES = hdc_pkg::LANES
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             update,
    input  hdc_pkg::sample_t sample,
    input  logic [DIM-1:0]   key,
    output logic             bound_valid,
    output hdc_pkg::bound_t  bound
);

    hdc_pkg::bound_t bound_nxt;
    logic [LANES-1:0][DIM-1:0] pos_key;

    // position key of lane i is the base key rotated left by i.
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            pos_key[i] = (key << i) | (key >> (DIM - i));  // the right shift is empty for i = 0.
        end
    end

    // bind the valid lanes and clear the rest, so the counters see plain ones.
    always_comb begin
        bound_nxt.lane_count = sample.lane_count;
        bound_nxt.first      = sample.first;
        bound_nxt.last       = sample.last;
        bound_nxt.tie        = sample.tie;
        for (int i = 0; i < LANES; i++) begin
            if (i < sample.lane_count) begin
                bound_nxt.lanes[i] = sample.lanes[i] ^ pos_key[i];
            end else begin
                bound_nxt.lanes[i] = '0;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bound_valid <= 1'b0;
        end else begin
            bound_valid <= update;
        end
    end

    // markers and tie ride along with the lanes, one sample per stage.
    always_ff @(posedge clk) begin
        if (update) begin
            bound <= bound_nxt;
        end
    end

endmodule

/* dim_counter.sv */
`timescale 1ns/100ps

module dim_counter #(
    parameter int LANES = hdc_pkg::LANES,
    parameter int CNT_W = hdc_pkg::CNT_W,
    localparam int LC_W = $clog2(LANES + 1)
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             valid,
    input  logic [LANES-1:0] lane_bits,
    input  logic [LC_W-1:0]  lane_count,
    input  logic             first,
    input  logic             last,
    input  logic             tie_bit,
    output logic             sign_bit
);

    logic [LC_W-1:0]  ones;       // ones of this dimension in the current sample.
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] total;
    logic [CNT_W-1:0] count_nxt;
    logic [CNT_W-1:0] total_nxt;
    logic [CNT_W:0]   twice;
    logic [CNT_W:0]   total_ext;
    logic             majority;

    // invalid lanes arrive as zero, so a plain popcount is enough.
    always_comb begin
        ones = '0;
        for (int l = 0; l < LANES; l++) begin
            ones = ones + LC_W'(lane_bits[l]);
        end
    end

    // first restarts the frame instead of adding to the old one.
    assign count_nxt = first ? CNT_W'(ones) : count + CNT_W'(ones);
    assign total_nxt = first ? CNT_W'(lane_count) : total + CNT_W'(lane_count);

    // sign is set when more than half the votes are ones.
    assign twice     = {count_nxt, 1'b0};
    assign total_ext = {1'b0, total_nxt};
    assign majority  = (twice > total_ext) || ((twice == total_ext) && tie_bit);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count    <= '0;
            total    <= '0;
            sign_bit <= 1'b0;
        end else if (valid) begin
            count <= count_nxt;
            total <= total_nxt;
            if (last) begin
                sign_bit <= majority;  // held until the next frame closes.
            end
        end
    end

endmodule

/* bundle_ctrl.sv */
`timescale 1ns/100ps

module bundle_ctrl #(
    parameter int DIM   = hdc_pkg::DIM,
    parameter int LANES = hdc_pkg::LANES,
    parameter int WORD  = hdc_pkg::WORD
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       bound_valid,
    input  hdc_pkg::bound_t            bound,
    input  logic                       stream_rd,
    input  logic [hdc_pkg::ADDR_W-1:0] stream_addr,
    output logic                       hv_done,
    output logic                       stream_valid,
    output logic [WORD-1:0]            stream_data
);

    logic [DIM-1:0] sign;        // one majority bit per dimension.
    logic [DIM-1:0] encoded_hv;  // last finished hypervector.
    logic           last_d;      // frame end, aligned with the settled signs.

    // one vote counter per dimension, fed with that bit of every lane.
    for (genvar d = 0; d < DIM; d++) begin : g_dim
        logic [LANES-1:0] lane_bits;

        always_comb begin
            for (int l = 0; l < LANES; l++) begin
                lane_bits[l] = bound.lanes[l][d];
            end
        end

        dim_counter #(
            .LANES (LANES),
            .CNT_W (hdc_pkg::CNT_W)
        ) dim_counter_i (
            .clk        (clk),
            .arst_n     (arst_n),
            .valid      (bound_valid),
            .lane_bits  (lane_bits),
            .lane_count (bound.lane_count),
            .first      (bound.first),
            .last       (bound.last),
            .tie_bit    (bound.tie[d]),
            .sign_bit   (sign[d])
        );
    end

    // signs settle one cycle after the last sample reaches the counters.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_d     <= 1'b0;
            hv_done    <= 1'b0;
            encoded_hv <= '0;
        end else begin
            last_d  <= bound_valid & bound.last;
            hv_done <= last_d;
            if (last_d) begin
                encoded_hv <= sign;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stream_valid <= 1'b0;
        end else begin
            stream_valid <= stream_rd;
        end
    end

    // slice 0 holds the low bits; a frame in progress does not disturb reads.
    always_ff @(posedge clk) begin
        if (stream_rd) begin
            stream_data <= encoded_hv[stream_addr * WORD +: WORD];
        end
    end

endmodule

/* hdc_encoder_top.sv */
`timescale 1ns/100ps

module hdc_encoder_top #(
    parameter int DIM   = hdc_pkg::DIM,
    parameter int LANES = hdc_pkg::LANES,
    parameter int WORD  = hdc_pkg::WORD
) (
    input  logic                       clk,
    input  logic                       arst_n,

    // sample input.
    input  logic                       update,
    input  hdc_pkg::sample_t           sample,
    input  logic [DIM-1:0]             key,  // static for the whole frame.

    // readout.
    input  logic                       stream_rd,
    input  logic [hdc_pkg::ADDR_W-1:0] stream_addr,
    output logic                       hv_done,
    output logic                       stream_valid,
    output logic [WORD-1:0]            stream_data
);

    logic            bound_valid;
    hdc_pkg::bound_t bound;

    hv_binder #(
        .DIM   (DIM),
        .LANES (LANES)
    ) hv_binder_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .update      (update),
        .sample      (sample),
        .key         (key),
        .bound_valid (bound_valid),
        .bound       (bound)
    );

    // counting, sign latch and stream port.
    bundle_ctrl #(
        .DIM   (DIM),
        .LANES (LANES),
        .WORD  (WORD)
    ) bundle_ctrl_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .bound_valid  (bound_valid),
        .bound        (bound),
        .stream_rd    (stream_rd),
        .stream_addr  (stream_addr),
        .hv_done      (hv_done),
        .stream_valid (stream_valid),
        .stream_data  (stream_data)
    );

endmodule

/* hdc_encoder_assert.sv */
`timescale 1ns/100ps

module hdc_encoder_assert #(
    parameter int WORD = hdc_pkg::WORD
) (
    input logic             clk,
    input logic             arst_n,
    input logic             update,
    input hdc_pkg::sample_t sample,
    input logic             hv_done,
    input logic             stream_rd,
    input logic             stream_valid,
    input logic [WORD-1:0]  stream_data
);

    int failures = 0;

    hv_done_single: assert property (@(posedge clk) disable iff (!arst_n)
        hv_done |=> !hv_done)
        else begin
            $error("hv_done held longer than one cycle.");
            failures++;
        end

    read_latency: assert property (@(posedge clk) disable iff (!arst_n)
        stream_rd |=> stream_valid)
        else begin
            $error("stream_valid missing one cycle after stream_rd.");
            failures++;
        end

    no_spurious_valid: assert property (@(posedge clk) disable iff (!arst_n)
        !stream_rd |=> !stream_valid)
        else begin
            $error("stream_valid without a read request.");
            failures++;
        end

    data_known: assert property (@(posedge clk) disable iff (!arst_n)
        stream_valid |-> !$isunknown(stream_data))
        else begin
            $error("stream_data has unknown bits while valid.");
            failures++;
        end

    lane_count_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
        update |-> (sample.lane_count != 0))
        else begin
            $error("update with a lane_count of zero.");
            failures++;
        end

endmodule

bind hdc_encoder_top hdc_encoder_assert #(.WORD(WORD)) hdc_encoder_assert_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .update       (update),
    .sample       (sample),
    .hv_done      (hv_done),
    .stream_rd    (stream_rd),
    .stream_valid (stream_valid),
    .stream_data  (stream_data)
);

/* hdc_checker.sv */
`timescale 1ns/100ps

module hdc_checker #(
    parameter int DIM  = hdc_pkg::DIM,
    parameter int WORD = hdc_pkg::WORD
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       update,
    input  hdc_pkg::sample_t           sample,
    input  logic                       hv_done,
    input  logic                       stream_valid,
    input  logic [WORD-1:0]            stream_data,
    output logic                       stream_rd,
    output logic [hdc_pkg::ADDR_W-1:0] stream_addr,
    output int                         errors,
    output int                         checked
);

    localparam int SLICES = DIM / WORD;

    logic [DIM-1:0] exp_q  [$];
    string          name_q [$];
    int             last_q [$];  // cycle of each closing update.
    int             cyc_cnt;     // index of the current cycle.

    // called by the driver when a frame starts.
    task automatic expect_hv(input logic [DIM-1:0] hv, input string name);
        exp_q.push_back(hv);
        name_q.push_back(name);
    endtask

    // pipelined reads, each slice is checked one cycle after its request.
    task automatic read_slices(input logic [DIM-1:0] hv, input string name);
        logic [WORD-1:0] want;
        stream_rd   = 1'b1;
        stream_addr = '0;
        for (int s = 1; s <= SLICES; s++) begin
            @(negedge clk);
            want = hv[(s-1)*WORD +: WORD];
            if (!stream_valid) begin
                $display("%s: no stream_valid for the read of slice %0d", name, s - 1);
                errors++;
            end else if (stream_data !== want) begin
                $display("[FAIL] %s slice %0d: expected %h, actual %h",
                         name, s - 1, want, stream_data);
                errors++;
            end
            if (s < SLICES) begin
                stream_addr = hdc_pkg::ADDR_W'(s);
            end else begin
                stream_rd = 1'b0;
            end
        end
    endtask

    initial begin
        stream_rd   = 1'b0;
        stream_addr = '0;
        errors      = 0;
        checked     = 0;
        cyc_cnt     = 0;
    end

    // an update seen at this edge belongs to the cycle that ends here.
    always @(posedge clk) begin
        if (arst_n && update && sample.last) begin
            last_q.push_back(cyc_cnt);
        end
        cyc_cnt++;
    end

    initial begin
        logic [DIM-1:0] hv;
        string          name;
        int             lc;
        forever begin
            @(negedge clk);
            if (arst_n && hv_done) begin
                lc = -1;
                if (last_q.size() == 0) begin
                    $display("hv_done pulsed with no closing sample before it");
                    errors++;
                end else begin
                    lc = last_q.pop_front();
                end
                if (exp_q.size() == 0) begin
                    $display("hv_done pulsed with no expected hypervector pending");
                    errors++;
                end else begin
                    hv   = exp_q.pop_front();
                    name = name_q.pop_front();
                    if (lc >= 0 && cyc_cnt - lc != 3) begin
                        $display("[FAIL] %s hv_done latency: expected 3, actual %0d",
                                 name, cyc_cnt - lc);
                        errors++;
                    end
                    read_slices(hv, name);
                    checked++;
                end
            end
        end
    end

endmodule

/* hdc_encoder_tb.sv */
`timescale 1ns/100ps

module hdc_encoder_tb;

    localparam int DIM   = hdc_pkg::DIM;
    localparam int LANES = hdc_pkg::LANES;
    localparam int WORD  = hdc_pkg::WORD;
    localparam int MAX_F = 32;   // frames the pattern file may hold.
    localparam int MAX_S = 256;  // samples over all frames.

    logic                       clk;
    logic                       arst_n;
    logic                       update;
    hdc_pkg::sample_t           sample;
    logic [DIM-1:0]             key;
    logic                       stream_rd;
    logic [hdc_pkg::ADDR_W-1:0] stream_addr;
    logic                       hv_done;
    logic                       stream_valid;
    logic [WORD-1:0]            stream_data;
    int                         errors;
    int                         checked;

    // frames as read from the pattern file.
    string            name_a [MAX_F];
    logic [DIM-1:0]   key_a  [MAX_F];
    int               ns_a   [MAX_F];
    int               b2b_a  [MAX_F];
    logic [DIM-1:0]   exp_a  [MAX_F];
    hdc_pkg::sample_t smp_a  [MAX_S];
    int               nf;
    int               ns_tot;
    int               wd_cycles;

    always #2 clk = ~clk;  // 4 ns period.

    hdc_encoder_top #(
        .DIM   (DIM),
        .LANES (LANES),
        .WORD  (WORD)
    ) hdc_encoder_top_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .update       (update),
        .sample       (sample),
        .key          (key),
        .stream_rd    (stream_rd),
        .stream_addr  (stream_addr),
        .hv_done      (hv_done),
        .stream_valid (stream_valid),
        .stream_data  (stream_data)
    );

    hdc_checker #(
        .DIM  (DIM),
        .WORD (WORD)
    ) hdc_checker_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .update       (update),
        .sample       (sample),
        .hv_done      (hv_done),
        .stream_valid (stream_valid),
        .stream_data  (stream_data),
        .stream_rd    (stream_rd),
        .stream_addr  (stream_addr),
        .errors       (errors),
        .checked      (checked)
    );

    // one line per record, lines starting with # are skipped.
    function automatic int load_patterns();
        int             fd;
        int             r;
        string          line;
        string          nm;
        logic [DIM-1:0] k;
        logic [DIM-1:0] t;
        logic [DIM-1:0] e;
        logic [DIM-1:0] lv [8];
        int             n;
        int             b;
        int             lc;
        int             fi;
        int             la;
        fd = $fopen("hdc_patterns.txt", "r");
        if (fd == 0) begin
            return 0;
        end
        while (!$feof(fd)) begin
            line = "";
            r = $fgets(line, fd);
            if (r == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            case (line[0])
                "F": begin
                    r = $sscanf(line, "F %s %h %d %d", nm, k, n, b);
                    name_a[nf] = nm;
                    key_a[nf]  = k;
                    ns_a[nf]   = n;
                    b2b_a[nf]  = b;
                    nf++;
                end
                "S": begin
                    r = $sscanf(line, "S %d %d %d %h %h %h %h %h %h %h %h", lc, fi, la,
                                lv[0], lv[1], lv[2], lv[3], lv[4], lv[5], lv[6], lv[7]);
                    for (int i = 0; i < LANES; i++) begin
                        smp_a[ns_tot].lanes[i] = lv[i];
                    end
                    smp_a[ns_tot].lane_count = hdc_pkg::LC_W'(lc);
                    smp_a[ns_tot].first      = fi[0];
                    smp_a[ns_tot].last       = la[0];
                    smp_a[ns_tot].tie        = '0;
                    ns_tot++;
                end
                "E": begin
                    r = $sscanf(line, "E %h %h", t, e);
                    exp_a[nf-1] = e;
                    smp_a[ns_tot-1].tie = t;  // tie rides on the closing sample.
                end
                default: ;
            endcase
        end
        $fclose(fd);
        return 1;
    endfunction

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("timeout: the DUT did not finish all frames within %0d cycles", wd_cycles);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int seed;
        int s;
        int gap;
        seed      = $urandom(83124);
        clk       = 1'b0;
        arst_n    = 1'b0;
        update    = 1'b0;
        sample    = '0;
        key       = '0;
        nf        = 0;
        ns_tot    = 0;
        wd_cycles = 0;
        if (load_patterns() == 0) begin
            $display("error: cannot open hdc_patterns.txt");
            $display("Result: FAILED");
            $finish;
        end else begin
            wd_cycles = ns_tot + nf * 8 + nf * (DIM / WORD) * 4 + 100;
            repeat (16) @(posedge clk);
            @(negedge clk);
            arst_n = 1'b1;
            s = 0;
            for (int f = 0; f < nf; f++) begin
                if (b2b_a[f] == 0) begin
                    gap = 6 + ($urandom % 4);  // leaves room for the readout.
                    repeat (gap) begin
                        @(negedge clk);
                        update = 1'b0;
                    end
                end
                hdc_checker_i.expect_hv(exp_a[f], name_a[f]);
                for (int j = 0; j < ns_a[f]; j++) begin
                    @(negedge clk);
                    update = 1'b1;
                    sample = smp_a[s];
                    key    = key_a[f];
                    s++;
                end
            end
            @(negedge clk);
            update = 1'b0;
            wait (checked == nf);
            repeat (4) @(negedge clk);
            $display("errors: %0d, assertion failures: %0d, frames checked: %0d of %0d",
                     errors, hdc_encoder_top_i.hdc_encoder_assert_i.failures, checked, nf);
            if (errors == 0 && hdc_encoder_top_i.hdc_encoder_assert_i.failures == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
            $finish;
        end
    end

endmodule

/* hdc_patterns.txt */
# F <name> <key hex> <samples> <back_to_back>
# S <lane_count> <first> <last> <lane0 .. lane7 hex>, E <tie hex> <expected hv hex>
#
# all lanes valid, key 0xFF rotated per lane.
F full_lanes_rotation 00000000000000FF 1 0
S 8 1 1 0 0 0 0 0 0 0 0
E 0 00000000000007F0
#
# only lanes 0..2 count, the high half of lanes 3..7 must be ignored.
F partial_lanes 0 1 0
S 3 1 1 FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF00000000 FFFFFFFF00000000 FFFFFFFF00000000 FFFFFFFF00000000 FFFFFFFF00000000
E 0 00000000FFFFFFFF
#
# every dimension ties at one of two.
F tie_break 0 1 0
S 2 1 1 FFFFFFFFFFFFFFFF 0 0 0 0 0 0 0
E 123456789ABCDEF0 123456789ABCDEF0
#
# three samples, one lane each.
F multi_sample_a 0 3 0
S 1 1 0 FF 0 0 0 0 0 0 0
S 1 0 0 FF0F 0 0 0 0 0 0 0
S 1 0 1 FF00FF 0 0 0 0 0 0 0
E 0 00000000000000FF
#
# follows the previous frame with no gap.
F multi_sample_b 0 5 1
S 1 1 0 FF00 0 0 0 0 0 0 0
S 1 0 0 F0F000 0 0 0 0 0 0 0
S 1 0 0 F000 0 0 0 0 0 0 0
S 1 0 0 F00000 0 0 0 0 0 0 0
S 1 0 1 0 0 0 0 0 0 0 0
E F00000 000000000000F000

/* flist.f */
hdc_pkg.sv
hv_binder.sv
dim_counter.sv
bundle_ctrl.sv
hdc_encoder_top.sv
hdc_encoder_assert.sv
hdc_checker.sv
hdc_encoder_tb.sv

/* Bender.yml */
package:
  name: hdc_encoder

sources:
  - files:
      - hdc_pkg.sv
      - hv_binder.sv
      - dim_counter.sv
      - bundle_ctrl.sv
      - hdc_encoder_top.sv
  - target: test
    files:
      - hdc_encoder_assert.sv
      - hdc_checker.sv
      - hdc_encoder_tb.sv
